// ==== hw/PECfg.sv ====
package PECfg;

    // ========================================================================
    // datapath word sizes
    // ========================================================================

    // pixel and weight word width
    localparam int PixWd = 8;

    // partial sum width, headroom for max taps x channels
    localparam int PsumWd = 20;

    // signed pixel / weight word
    typedef logic signed [PixWd-1:0] Pix;

    // signed partial sum word
    typedef logic signed [PsumWd-1:0] Psum;

    // ========================================================================
    // default array sizes for the top level
    // ========================================================================

    // max filter taps per channel
    localparam int DefMaxFiltW = 4;

    // max output positions in one psum row
    localparam int DefMaxOutW = 16;

    // max input channels held in the pads
    localparam int DefMaxCh = 4;

endpackage

// ==== hw/PECtlCfg.sv ====
package PECtlCfg;

    // controller phases, idle -> load -> compute -> flush -> drain
    typedef enum logic [2:0] {
        StIdle,
        StLoad,
        StCompute,
        StFlush,
        StDrain
    } CtlState;

    // sum stage start value
    // zero for first tap of first channel, else stored psum
    typedef enum logic {
        PsumZero,
        PsumRead
    } PsumInit;

endpackage

// ==== hw/PadMem.sv ====
`timescale 1ns/1ps

module PadMem #(
    parameter int Depth = 16,
    parameter int Wd    = 8
) (
    input  logic                     i_clk,
    input  logic                     i_wrEn,
    input  logic [$clog2(Depth)-1:0] i_wrAddr,
    input  logic [Wd-1:0]            i_wrData,
    input  logic [$clog2(Depth)-1:0] i_rdAddr,
    output logic [Wd-1:0]            o_rdData
);

    // scratchpad storage
    logic [Wd-1:0] mem [Depth];

    // read data register
    logic [Wd-1:0] rdData;

    // ========================================================================
    // write port
    // ========================================================================

    always_ff @(posedge i_clk) begin
        if (i_wrEn) begin
            mem[i_wrAddr] <= i_wrData;
        end
    end

    // ========================================================================
    // read port, one cycle latency
    // ========================================================================

    // same-edge write is not visible, old word comes out
    always_ff @(posedge i_clk) begin
        rdData <= mem[i_rdAddr];
    end

    assign o_rdData = rdData;

endmodule

// ==== hw/DataPathController.sv ====
`timescale 1ns/1ps

module DataPathController #(
    parameter int MaxFiltW = PECfg::DefMaxFiltW,
    parameter int MaxOutW  = PECfg::DefMaxOutW,
    parameter int MaxCh    = PECfg::DefMaxCh,
    // config field widths
    localparam int FiltWd  = $clog2(MaxFiltW + 1),
    localparam int OutWd   = $clog2(MaxOutW + 1),
    localparam int ChWd    = $clog2(MaxCh + 1),
    // pad sizes
    localparam int IpDepth = MaxCh * (MaxOutW + MaxFiltW - 1),
    localparam int WpDepth = MaxCh * MaxFiltW,
    localparam int IpAw    = $clog2(IpDepth),
    localparam int WpAw    = $clog2(WpDepth),
    localparam int PpAw    = $clog2(MaxOutW)
) (
    input  logic                i_clk,
    input  logic                i_rstN,
    input  logic                i_start,
    input  logic [FiltWd-1:0]   i_filtW,
    input  logic [OutWd-1:0]    i_outW,
    input  logic [ChWd-1:0]     i_numCh,
    input  logic                i_ipixValid,
    input  logic                i_wpixValid,
    output logic                o_loading,
    output logic [IpAw-1:0]     o_ipWrAddr,
    output logic [WpAw-1:0]     o_wpWrAddr,
    output logic [IpAw-1:0]     o_ipRdAddr,
    output logic [WpAw-1:0]     o_wpRdAddr,
    output logic [PpAw-1:0]     o_ppRdAddr,
    output logic [PpAw-1:0]     o_ppWrAddr,
    output logic                o_FS_valid,
    output logic                o_MS_valid,
    output logic                o_SS_valid,
    output logic                o_SS_fstpix,
    output logic                o_SS_last,
    output PECtlCfg::PsumInit   o_SS_init,
    output logic                o_drainValid,
    output logic                o_done
);

    // counter widths, one above the largest count
    localparam int IpCntWd = $clog2(IpDepth + 1);
    localparam int WpCntWd = $clog2(WpDepth + 1);

    PECtlCfg::CtlState state;

    // latched config
    logic [FiltWd-1:0] filtW;
    logic [OutWd-1:0]  outW;
    logic [ChWd-1:0]   numCh;

    // load counters double as pad write addresses
    logic [IpCntWd-1:0] ipCnt, ipCntNx, ipTotal, rowLen, ipRdFull;
    logic [WpCntWd-1:0] wpCnt, wpCntNx, wpTotal, wpRdFull;
    logic               loadDone;

    // loop counters, c outer, s middle, x inner
    logic [ChWd-1:0]   chCnt;
    logic [FiltWd-1:0] tapCnt;
    logic [OutWd-1:0]  xCnt;
    logic              xLast, tapLast, chLast, firstTap, issue, issueLast;

    // per-stage control, fetch / mult / sum
    logic              fsValid, msValid, ssValid;
    logic              fsFst, msFst, ssFst;
    logic              fsLast, msLast, ssLast;
    logic [PpAw-1:0]   fsIdx, msIdx, ssIdx;
    PECtlCfg::PsumInit fsInit;

    // drain end delay line
    logic doneD1, doneR;

    // ==========================================================================
    // comb
    // ==========================================================================

    // pixels per channel row
    assign rowLen  = IpCntWd'(outW) + IpCntWd'(filtW) - IpCntWd'(1);
    assign ipTotal = IpCntWd'(numCh) * rowLen;
    assign wpTotal = WpCntWd'(numCh) * WpCntWd'(filtW);

    assign o_loading = (state == PECtlCfg::StLoad);
    // saturate at total, stray strobes past the end are dropped
    assign ipCntNx = ipCnt + IpCntWd'(o_loading && i_ipixValid && ipCnt != ipTotal);
    assign wpCntNx = wpCnt + WpCntWd'(o_loading && i_wpixValid && wpCnt != wpTotal);
    assign loadDone = o_loading && (ipCntNx == ipTotal) && (wpCntNx == wpTotal);

    assign o_ipWrAddr = ipCnt[IpAw-1:0];
    assign o_wpWrAddr = wpCnt[WpAw-1:0];

    assign xLast     = (xCnt == outW - OutWd'(1));
    assign tapLast   = (tapCnt == filtW - FiltWd'(1));
    assign chLast    = (chCnt == numCh - ChWd'(1));
    assign firstTap  = (chCnt == '0) && (tapCnt == '0);
    assign issue     = (state == PECtlCfg::StCompute);
    assign issueLast = xLast && tapLast && chLast;

    // ipad: c * rowLen + x + s, wpad: c * filtW + s
    assign ipRdFull = IpCntWd'(chCnt) * rowLen + IpCntWd'(xCnt) + IpCntWd'(tapCnt);
    assign wpRdFull = WpCntWd'(chCnt) * WpCntWd'(filtW) + WpCntWd'(tapCnt);
    assign o_ipRdAddr = ipRdFull[IpAw-1:0];
    assign o_wpRdAddr = wpRdFull[WpAw-1:0];
    // x counter serves compute reads and drain reads
    assign o_ppRdAddr = xCnt[PpAw-1:0];

    // ==========================================================================
    // sequential
    // ==========================================================================

    always_ff @(posedge i_clk) begin
        if (state == PECtlCfg::StIdle && i_start) begin
            filtW <= i_filtW;
            outW  <= i_outW;
            numCh <= i_numCh;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            state  <= PECtlCfg::StIdle;
            ipCnt  <= '0;
            wpCnt  <= '0;
            chCnt  <= '0;
            tapCnt <= '0;
            xCnt   <= '0;
        end else begin
            case (state)
                PECtlCfg::StIdle: begin
                    if (i_start) begin
                        ipCnt <= '0;
                        wpCnt <= '0;
                        state <= PECtlCfg::StLoad;
                    end
                end
                PECtlCfg::StLoad: begin
                    ipCnt <= ipCntNx;
                    wpCnt <= wpCntNx;
                    if (loadDone) begin
                        chCnt  <= '0;
                        tapCnt <= '0;
                        xCnt   <= '0;
                        state  <= PECtlCfg::StCompute;
                    end
                end
                PECtlCfg::StCompute: begin
                    // one MAC per cycle, x wraps back to 0 on the last issue
                    if (xLast) begin
                        xCnt <= '0;
                        if (tapLast) begin
                            tapCnt <= '0;
                            chCnt  <= chCnt + ChWd'(1);
                        end else begin
                            tapCnt <= tapCnt + FiltWd'(1);
                        end
                    end else begin
                        xCnt <= xCnt + OutWd'(1);
                    end
                    if (issueLast) begin
                        state <= PECtlCfg::StFlush;
                    end
                end
                PECtlCfg::StFlush: begin
                    // wait for final write-back
                    if (ssLast) begin
                        state <= PECtlCfg::StDrain;
                    end
                end
                PECtlCfg::StDrain: begin
                    xCnt <= xLast ? '0 : xCnt + OutWd'(1);
                    if (xLast) begin
                        state <= PECtlCfg::StIdle;
                    end
                end
                default: state <= PECtlCfg::StIdle;
            endcase
        end
    end

    // stage strobes, issue delayed by 1, 2, 3
    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            fsValid <= 1'b0;
            msValid <= 1'b0;
            ssValid <= 1'b0;
            fsFst   <= 1'b0;
            msFst   <= 1'b0;
            ssFst   <= 1'b0;
            fsLast  <= 1'b0;
            msLast  <= 1'b0;
            ssLast  <= 1'b0;
            doneD1  <= 1'b0;
            doneR   <= 1'b0;
        end else begin
            fsValid <= issue;
            fsFst   <= issue && firstTap;
            fsLast  <= issue && issueLast;
            msValid <= fsValid;
            msFst   <= fsFst;
            msLast  <= fsLast;
            ssValid <= msValid;
            ssFst   <= msFst;
            ssLast  <= msLast;
            // done lands one cycle after the last psum strobe
            doneD1  <= o_drainValid && xLast;
            doneR   <= doneD1;
        end
    end

    // psum index and init code follow the strobes
    always_ff @(posedge i_clk) begin
        fsIdx  <= xCnt[PpAw-1:0];
        fsInit <= firstTap ? PECtlCfg::PsumZero : PECtlCfg::PsumRead;
        msIdx  <= fsIdx;
        ssIdx  <= msIdx;
    end

    assign o_FS_valid   = fsValid;
    assign o_MS_valid   = msValid;
    assign o_SS_valid   = ssValid;
    assign o_SS_fstpix  = ssFst;
    assign o_SS_last    = ssLast;
    // init code is consumed alongside fetched data
    assign o_SS_init    = fsInit;
    assign o_ppWrAddr   = ssIdx;
    assign o_drainValid = (state == PECtlCfg::StDrain);
    assign o_done       = doneR;

endmodule

// ==== hw/MacPipe.sv ====
`timescale 1ns/1ps

module MacPipe (
    input  logic              i_clk,
    input  logic              i_rstN,
    input  logic              i_FS_valid,
    input  logic              i_MS_valid,
    input  PECtlCfg::PsumInit i_SS_init,
    input  PECfg::Pix         i_ipix,
    input  PECfg::Pix         i_wpix,
    input  PECfg::Psum        i_ppRd,
    output PECfg::Psum        o_ssSum
);

    // full-width signed product
    logic signed [2*PECfg::PixWd-1:0] prod;

    // mult stage registers
    PECfg::Psum        msProd;
    PECfg::Psum        msPsum;
    PECtlCfg::PsumInit msInit;

    // sum stage
    PECfg::Psum base;
    PECfg::Psum ssSum;

    // ========================================================================
    // mult stage
    // ========================================================================

    assign prod = i_ipix * i_wpix;

    // product sign extended into psum width
    always_ff @(posedge i_clk) begin
        if (i_FS_valid) begin
            msProd <= PECfg::Psum'(prod);
            msPsum <= i_ppRd;
        end
    end

    // init code rides with the operands
    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            msInit <= PECtlCfg::PsumZero;
        end else if (i_FS_valid) begin
            msInit <= i_SS_init;
        end
    end

    // ========================================================================
    // sum stage
    // ========================================================================

    // first tap of first channel starts from zero
    assign base = (msInit == PECtlCfg::PsumZero) ? '0 : msPsum;

    // held as ppad write-back data
    always_ff @(posedge i_clk) begin
        if (i_MS_valid) begin
            ssSum <= base + msProd;
        end
    end

    assign o_ssSum = ssSum;

endmodule

// ==== hw/ProcessingElement.sv ====
`timescale 1ns/1ps

module ProcessingElement #(
    parameter int MaxFiltW = PECfg::DefMaxFiltW,
    parameter int MaxOutW  = PECfg::DefMaxOutW,
    parameter int MaxCh    = PECfg::DefMaxCh
) (
    input  logic                         i_clk,
    input  logic                         i_rstN,
    input  logic                         i_start,
    input  logic [$clog2(MaxFiltW+1)-1:0] i_filtW,
    input  logic [$clog2(MaxOutW+1)-1:0]  i_outW,
    input  logic [$clog2(MaxCh+1)-1:0]    i_numCh,
    input  logic                         i_ipixValid,
    input  PECfg::Pix                    i_ipix,
    input  logic                         i_wpixValid,
    input  PECfg::Pix                    i_wpix,
    output logic                         o_fwdValid,
    output PECfg::Pix                    o_fwdPix,
    output logic                         o_psumValid,
    output PECfg::Psum                   o_psum,
    output logic                         o_done
);

    // ========================================================================
    // pad sizes
    // ========================================================================

    localparam int IpDepth = MaxCh * (MaxOutW + MaxFiltW - 1);
    localparam int WpDepth = MaxCh * MaxFiltW;
    localparam int PpDepth = MaxOutW;
    localparam int IpAw    = $clog2(IpDepth);
    localparam int WpAw    = $clog2(WpDepth);
    localparam int PpAw    = $clog2(PpDepth);

    // pad addresses
    logic [IpAw-1:0] ipWrAddr, ipRdAddr;
    logic [WpAw-1:0] wpWrAddr, wpRdAddr;
    logic [PpAw-1:0] ppWrAddr, ppRdAddr;

    // controller strobes
    logic              loading, fsValid, msValid, ssValid, drainValid;
    PECtlCfg::PsumInit ssInit;

    // pad read data and write-back sum
    PECfg::Pix  ipRd, wpRd;
    PECfg::Psum ppRd, ssSum;

    // forward and drain registers
    logic      fwdValid, psumValid;
    PECfg::Pix fwdPix;

    DataPathController #(
        .MaxFiltW (MaxFiltW),
        .MaxOutW  (MaxOutW),
        .MaxCh    (MaxCh)
    ) ctl0 (
        .i_clk        (i_clk),
        .i_rstN       (i_rstN),
        .i_start      (i_start),
        .i_filtW      (i_filtW),
        .i_outW       (i_outW),
        .i_numCh      (i_numCh),
        .i_ipixValid  (i_ipixValid),
        .i_wpixValid  (i_wpixValid),
        .o_loading    (loading),
        .o_ipWrAddr   (ipWrAddr),
        .o_wpWrAddr   (wpWrAddr),
        .o_ipRdAddr   (ipRdAddr),
        .o_wpRdAddr   (wpRdAddr),
        .o_ppRdAddr   (ppRdAddr),
        .o_ppWrAddr   (ppWrAddr),
        .o_FS_valid   (fsValid),
        .o_MS_valid   (msValid),
        .o_SS_valid   (ssValid),
        .o_SS_fstpix  (),
        .o_SS_last    (),
        .o_SS_init    (ssInit),
        .o_drainValid (drainValid),
        .o_done       (o_done)
    );

    // input pixels, channel-major
    PadMem #(.Depth(IpDepth), .Wd(PECfg::PixWd)) ipad0 (
        .i_clk    (i_clk),
        .i_wrEn   (i_ipixValid && loading),
        .i_wrAddr (ipWrAddr),
        .i_wrData (i_ipix),
        .i_rdAddr (ipRdAddr),
        .o_rdData (ipRd)
    );

    // weights, channel-major
    PadMem #(.Depth(WpDepth), .Wd(PECfg::PixWd)) wpad0 (
        .i_clk    (i_clk),
        .i_wrEn   (i_wpixValid && loading),
        .i_wrAddr (wpWrAddr),
        .i_wrData (i_wpix),
        .i_rdAddr (wpRdAddr),
        .o_rdData (wpRd)
    );

    // psum row, written back by the sum stage
    PadMem #(.Depth(PpDepth), .Wd(PECfg::PsumWd)) ppad0 (
        .i_clk    (i_clk),
        .i_wrEn   (ssValid),
        .i_wrAddr (ppWrAddr),
        .i_wrData (ssSum),
        .i_rdAddr (ppRdAddr),
        .o_rdData (ppRd)
    );

    MacPipe mac0 (
        .i_clk      (i_clk),
        .i_rstN     (i_rstN),
        .i_FS_valid (fsValid),
        .i_MS_valid (msValid),
        .i_SS_init  (ssInit),
        .i_ipix     (ipRd),
        .i_wpix     (wpRd),
        .i_ppRd     (ppRd),
        .o_ssSum    (ssSum)
    );

    // ========================================================================
    // forward and drain registers
    // ========================================================================

    // every pixel strobe goes on to the neighbour, load phase or not
    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            fwdValid  <= 1'b0;
            psumValid <= 1'b0;
        end else begin
            fwdValid  <= i_ipixValid;
            psumValid <= drainValid;
        end
    end

    always_ff @(posedge i_clk) begin
        fwdPix <= i_ipix;
    end

    assign o_fwdValid  = fwdValid;
    assign o_fwdPix    = fwdPix;
    // ppad read data already lines up with the delayed strobe
    assign o_psumValid = psumValid;
    assign o_psum      = ppRd;

endmodule

// ==== bench/PeTb.sv ====
`timescale 1ns/1ps

module PeTb;

    // ========================================================================
    // sizes and run settings
    // ========================================================================

    localparam int MaxFiltW = PECfg::DefMaxFiltW;
    localparam int MaxOutW  = PECfg::DefMaxOutW;
    localparam int MaxCh    = PECfg::DefMaxCh;
    localparam int FiltWd   = $clog2(MaxFiltW + 1);
    localparam int OutWd    = $clog2(MaxOutW + 1);
    localparam int ChWd     = $clog2(MaxCh + 1);
    localparam int RowMax   = MaxOutW + MaxFiltW - 1;
    localparam int NumTests = 16;
    localparam int ClkNs    = 100;
    localparam int unsigned RandSeed = 32'h5688_44ad;

    // data patterns, random or signed extremes
    localparam int DataRand   = 0;
    localparam int DataMinMin = 1;
    localparam int DataMinMax = 2;
    localparam PECfg::Pix PixMin = 8'sh80;
    localparam PECfg::Pix PixMax = 8'sh7f;

    logic              clk;
    logic              rstN;
    logic              start;
    logic [FiltWd-1:0] filtW;
    logic [OutWd-1:0]  outW;
    logic [ChWd-1:0]   numCh;
    logic              ipixValid;
    PECfg::Pix         ipix;
    logic              wpixValid;
    PECfg::Pix         wpix;
    logic              fwdValid;
    PECfg::Pix         fwdPix;
    logic              psumValid;
    PECfg::Psum        psum;
    logic              done;

    // per-test configuration table
    int cfgCh [NumTests];
    int cfgFw [NumTests];
    int cfgOw [NumTests];
    int cfgData [NumTests];
    bit cfgStray [NumTests];

    // copies of what was loaded, for the reference model
    PECfg::Pix pixMem [MaxCh][RowMax];
    PECfg::Pix wtMem [MaxCh][MaxFiltW];

    // checker state
    PECfg::Psum  expQ [$];
    PECfg::Psum  expVal;
    int          runOutW;
    int          runPsums;
    int          doneCount;
    logic        prevPsumValid;
    logic        fwdExpValid;
    PECfg::Pix   fwdExpPix;
    int          budgetNs;
    bit          budgetReady;
    int unsigned seedVal;

    ProcessingElement dut0 (
        .i_clk       (clk),
        .i_rstN      (rstN),
        .i_start     (start),
        .i_filtW     (filtW),
        .i_outW      (outW),
        .i_numCh     (numCh),
        .i_ipixValid (ipixValid),
        .i_ipix      (ipix),
        .i_wpixValid (wpixValid),
        .i_wpix      (wpix),
        .o_fwdValid  (fwdValid),
        .o_fwdPix    (fwdPix),
        .o_psumValid (psumValid),
        .o_psum      (psum),
        .o_done      (done)
    );

    always #(ClkNs / 2) clk = ~clk;

    // ========================================================================
    // reference model and compare tasks
    // ========================================================================

    // psum[x] = sum over c, s of ipix[c][x+s] * weight[c][s]
    function automatic PECfg::Psum refPsum(int x, int ch, int fw);
        int acc;
        acc = 0;
        for (int c = 0; c < ch; c++) begin
            for (int s = 0; s < fw; s++) begin
                acc += int'(pixMem[c][x + s]) * int'(wtMem[c][s]);
            end
        end
        return PECfg::Psum'(acc);
    endfunction

    task automatic stopRun();
        $display("Test failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic checkPsum(string name, PECfg::Psum expV, PECfg::Psum actV);
        if (actV !== expV) begin
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, expV, actV);
            stopRun();
        end
    endtask

    task automatic checkPix(string name, PECfg::Pix expV, PECfg::Pix actV);
        if (actV !== expV) begin
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, expV, actV);
            stopRun();
        end
    endtask

    task automatic checkFlag(string name, logic expV, logic actV);
        if (actV !== expV) begin
            $display("[FAIL] %0t %s expected %b got %b", $time, name, expV, actV);
            stopRun();
        end
    endtask

    // ========================================================================
    // stimulus helpers
    // ========================================================================

    // inputs change 1 ns after the rising edge
    task automatic nextSlot();
        @(posedge clk);
        #1;
    endtask

    function automatic PECfg::Pix makePix(int mode);
        if (mode == DataRand) return PECfg::Pix'($urandom);
        return PixMin;
    endfunction

    function automatic PECfg::Pix makeWt(int mode);
        if (mode == DataRand) return PECfg::Pix'($urandom);
        if (mode == DataMinMin) return PixMin;
        return PixMax;
    endfunction

    task automatic driveQuiet();
        ipixValid = 1'b0;
        wpixValid = 1'b0;
        ipix      = PECfg::Pix'($urandom);
        wpix      = PECfg::Pix'($urandom);
    endtask

    // random strobes the PE must not store
    task automatic driveStray();
        ipixValid = 1'($urandom_range(1, 0));
        wpixValid = 1'($urandom_range(1, 0));
        ipix      = PECfg::Pix'($urandom);
        wpix      = PECfg::Pix'($urandom);
    endtask

    // test table and watchdog budget in one pass
    task automatic buildTests();
        int cycles;
        int loads;
        // reset plus margin
        cycles = 5 + 100;
        for (int t = 0; t < NumTests; t++) begin
            cfgStray[t] = 1'b0;
            cfgData[t]  = DataRand;
            if (t < 3) begin
                // one channel, one tap, short to full row
                cfgCh[t] = 1;
                cfgFw[t] = 1;
                cfgOw[t] = 4 + t * 6;
            end else if (t < 5) begin
                cfgCh[t]   = MaxCh;
                cfgFw[t]   = MaxFiltW;
                cfgOw[t]   = MaxOutW;
                cfgData[t] = (t == 3) ? DataMinMin : DataMinMax;
            end else begin
                cfgCh[t]    = $urandom_range(MaxCh, 1);
                cfgFw[t]    = $urandom_range(MaxFiltW, 1);
                cfgOw[t]    = $urandom_range(MaxOutW, 4);
                cfgStray[t] = (t % 3 == 0);
            end
            loads = cfgCh[t] * (cfgOw[t] + cfgFw[t] - 1) + cfgCh[t] * cfgFw[t];
            // at most one empty load cycle per strobe
            cycles += 2 * loads + cfgCh[t] * cfgFw[t] * cfgOw[t] + cfgOw[t] + 20 + 6;
        end
        budgetNs = cycles * ClkNs;
    endtask

    // one full run, entered and left at a drive slot
    task automatic runTest(int t);
        int ch, fw, ow, rowLen;
        int ipLeft, wpLeft, ipIdx, wpIdx;
        bit wantIp, wantWp, hadGap;
        ch     = cfgCh[t];
        fw     = cfgFw[t];
        ow     = cfgOw[t];
        rowLen = ow + fw - 1;
        ipLeft = ch * rowLen;
        wpLeft = ch * fw;
        ipIdx  = 0;
        wpIdx  = 0;
        hadGap = 1'b0;
        if (cfgStray[t]) begin
            repeat (4) begin
                driveStray();
                nextSlot();
            end
        end
        driveQuiet();
        start = 1'b1;
        filtW = FiltWd'(fw);
        outW  = OutWd'(ow);
        numCh = ChWd'(ch);
        nextSlot();
        start = 1'b0;
        // interleaved load, both streams may hit the same cycle
        while (ipLeft > 0 || wpLeft > 0) begin
            driveQuiet();
            wantIp = (ipLeft > 0) && ($urandom_range(3, 0) != 0);
            wantWp = (wpLeft > 0) && ($urandom_range(3, 0) != 0);
            if (!wantIp && !wantWp) begin
                if (hadGap) begin
                    wantIp = (ipLeft > 0);
                    wantWp = (ipLeft == 0);
                end
                hadGap = !hadGap;
            end else begin
                hadGap = 1'b0;
            end
            if (wantIp) begin
                ipix      = makePix(cfgData[t]);
                ipixValid = 1'b1;
                pixMem[ipIdx / rowLen][ipIdx % rowLen] = ipix;
                ipIdx++;
                ipLeft--;
            end
            if (wantWp) begin
                wpix      = makeWt(cfgData[t]);
                wpixValid = 1'b1;
                wtMem[wpIdx / fw][wpIdx % fw] = wpix;
                wpIdx++;
                wpLeft--;
            end
            nextSlot();
        end
        // expected row goes out in x order
        runOutW = ow;
        for (int x = 0; x < ow; x++) begin
            expQ.push_back(refPsum(x, ch, fw));
        end
        while (!done) begin
            if (cfgStray[t]) driveStray();
            else driveQuiet();
            nextSlot();
        end
        driveQuiet();
    endtask

    // ========================================================================
    // monitor, sampled at the falling edge
    // ========================================================================

    always @(negedge clk) begin
        if (rstN) begin
            // forward path, one cycle behind the pixel strobe
            checkFlag("o_fwdValid", fwdExpValid, fwdValid);
            if (fwdExpValid) checkPix("o_fwdPix", fwdExpPix, fwdPix);
            if (psumValid) begin
                if (expQ.size() == 0) begin
                    $display("ERROR: o_psumValid high at %0t with no psum expected", $time);
                    stopRun();
                end else if (runPsums > 0 && !prevPsumValid) begin
                    $display("ERROR: psum strobes of one run were not back to back");
                    stopRun();
                end else begin
                    expVal = expQ.pop_front();
                    checkPsum("o_psum", expVal, psum);
                    runPsums++;
                end
            end
            if (done) begin
                if (!prevPsumValid || runPsums != runOutW) begin
                    $display("ERROR: o_done at %0t after %0d of %0d psums, not right after the last",
                             $time, runPsums, runOutW);
                    stopRun();
                end
                doneCount++;
                runPsums = 0;
            end
            prevPsumValid = psumValid;
        end
        // inputs seen now are taken at the next rising edge
        fwdExpValid = ipixValid;
        fwdExpPix   = ipix;
    end

    // watchdog, sized from the test table
    initial begin
        wait (budgetReady);
        #(budgetNs);
        $display("ERROR: run timed out after %0d ns before all tests finished", budgetNs);
        stopRun();
    end

    // ========================================================================
    // main sequence
    // ========================================================================

    initial begin
        clk           = 1'b0;
        rstN          = 1'b0;
        start         = 1'b0;
        filtW         = '0;
        outW          = '0;
        numCh         = '0;
        ipixValid     = 1'b0;
        ipix          = '0;
        wpixValid     = 1'b0;
        wpix          = '0;
        runOutW       = 0;
        runPsums      = 0;
        doneCount     = 0;
        prevPsumValid = 1'b0;
        fwdExpValid   = 1'b0;
        fwdExpPix     = '0;
        $timeformat(-9, 0, " ns", 0);
        seedVal = $urandom(RandSeed);
        buildTests();
        budgetReady = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rstN = 1'b1;
        // back to back, each start right after the previous done
        for (int t = 0; t < NumTests; t++) begin
            runTest(t);
        end
        repeat (3) nextSlot();
        if (doneCount != NumTests || expQ.size() != 0) begin
            $display("ERROR: %0d of %0d runs finished, %0d psums never came out",
                     doneCount, NumTests, expQ.size());
            stopRun();
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// ==== sources.f ====
hw/PECfg.sv
hw/PECtlCfg.sv
hw/PadMem.sv
hw/DataPathController.sv
hw/MacPipe.sv
hw/ProcessingElement.sv
bench/PeTb.sv

// ==== Makefile ====
# Verilator build and run for the processing element testbench
# override any variable on the command line, e.g. make LOG=run.log

VERILATOR ?= verilator
TOP       ?= PeTb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Test passed" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
